// File: src/isa_pkg.sv
package isa_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// datapath widths.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int xlen         = 64;	// register width.
	localparam int wlen         = 32;	// operand width of the W forms.
	localparam int shamt_bits   = 6;	// shift amount for 64-bit shifts.
	localparam int shamt_w_bits = 5;	// shift amount for 32-bit shifts.

	localparam int alu_op_num   = 22;	// highest defined operation code.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// alu operation codes.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [4:0] {
		alu_nop  = 5'd0,	// bubble, no operation.
		alu_add  = 5'd1,
		alu_slt  = 5'd2,
		alu_sltu = 5'd3,
		alu_xor  = 5'd4,
		alu_or   = 5'd5,
		alu_and  = 5'd6,
		alu_sll  = 5'd7,
		alu_srl  = 5'd8,
		alu_sra  = 5'd9,
		alu_sub  = 5'd10,
		alu_lui  = 5'd11,	// passes op2 through.
		alu_beq  = 5'd12,
		alu_bne  = 5'd13,
		alu_blt  = 5'd14,
		alu_bge  = 5'd15,
		alu_bltu = 5'd16,
		alu_bgeu = 5'd17,
		alu_addw = 5'd18,
		alu_subw = 5'd19,
		alu_sllw = 5'd20,
		alu_srlw = 5'd21,
		alu_sraw = 5'd22
	} alu_op_t;

endpackage

// File: src/pipe_pkg.sv
package pipe_pkg;

	// where rs1 and rs2 come from.
	typedef enum logic [1:0] {
		fwd_reg = 2'd0,	// register file read data.
		fwd_mem = 2'd1,	// result held in the execute/memory register.
		fwd_wb  = 2'd2	// write-back data.
	} fwd_sel_t;

	typedef enum logic {
		op1_rs1 = 1'b0,
		op1_pc  = 1'b1
	} op1_sel_t;

	typedef enum logic [1:0] {
		op2_rs2  = 2'd0,
		op2_imm  = 2'd1,
		op2_four = 2'd2	// constant 4 for link addresses.
	} op2_sel_t;

	typedef enum logic {
		base_pc  = 1'b0,	// branches and jal.
		base_rs1 = 1'b1	// jalr.
	} pc_base_t;

endpackage

// File: src/adder64.sv
`timescale 1ns/1ps

module adder64 import isa_pkg::*; (
	input  logic [xlen-1:0] op1,
	input  logic [xlen-1:0] op2,
	input  logic            cin,
	output logic [xlen-1:0] sum,
	output logic            zero,
	output logic            sign,
	output logic            overflow,
	output logic            carry
);

	logic [xlen:0] wide_sum;	// carry-out sits in the top bit.

	assign wide_sum = {1'b0, op1} + {1'b0, op2} + {{xlen{1'b0}}, cin};
	assign sum      = wide_sum[xlen-1:0];

	assign zero = (sum == '0);
	assign sign = sum[xlen-1];

	// operands share a sign and the sum flips it.
	assign overflow = (op1[xlen-1] == op2[xlen-1]) && (sum[xlen-1] != op1[xlen-1]);

	// subtraction sets cin, so the carry-out is inverted into a borrow.
	assign carry = wide_sum[xlen] ^ cin;

endmodule

// File: src/operand_select.sv
`timescale 1ns/1ps

module operand_select import isa_pkg::*, pipe_pkg::*; (
	input  fwd_sel_t        rs1_src,
	input  fwd_sel_t        rs2_src,
	input  op1_sel_t        op1_src,
	input  op2_sel_t        op2_src,
	input  logic [xlen-1:0] rs1_data,
	input  logic [xlen-1:0] rs2_data,
	input  logic [xlen-1:0] mem_result,
	input  logic [xlen-1:0] wb_rd_data,
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] imm,
	output logic [xlen-1:0] new_rs1,
	output logic [xlen-1:0] new_rs2,
	output logic [xlen-1:0] op1,
	output logic [xlen-1:0] op2
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// forwarding.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [xlen-1:0] forward(
		input fwd_sel_t        sel,
		input logic [xlen-1:0] reg_val,
		input logic [xlen-1:0] mem_val,
		input logic [xlen-1:0] wb_val
	);
		case (sel)
			fwd_mem: return mem_val;	// previous instruction's result.
			fwd_wb:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign new_rs1 = forward(rs1_src, rs1_data, mem_result, wb_rd_data);
	assign new_rs2 = forward(rs2_src, rs2_data, mem_result, wb_rd_data);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// alu operands.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign op1 = (op1_src == op1_pc) ? pc : new_rs1;	// pc for auipc and links.

	always_comb begin
		case (op2_src)
			op2_imm:  op2 = imm;
			op2_four: op2 = xlen'(4);
			default:  op2 = new_rs2;
		endcase
	end

	// decode never sends the spare encoding on any select.
	always_comb begin
		assert (rs1_src != 2'd3 && rs2_src != 2'd3 && op2_src != 2'd3)
			else $error("operand_select: reserved select %0d %0d %0d",
				rs1_src, rs2_src, op2_src);
	end

endmodule

// File: src/alu_core.sv
`timescale 1ns/1ps

module alu_core import isa_pkg::*; (
	input  logic            clk,
	input  logic            reset,
	input  alu_op_t         alu_op,
	input  logic [xlen-1:0] op1,
	input  logic [xlen-1:0] op2,
	output logic [xlen-1:0] result,
	output logic            zero,
	output logic            lt_signed,
	output logic            lt_unsigned
);

	logic [alu_op_num:1]     op_dec;	// one bit per operation, none for nop.
	logic                    sub_path;
	logic [xlen-1:0]         op2_add;
	logic [xlen-1:0]         add_sum;
	logic                    add_sign;
	logic                    add_ovf;
	logic [shamt_bits-1:0]   shamt;
	logic [shamt_w_bits-1:0] shamt_w;
	logic [xlen-1:0]         sll_res;
	logic [xlen-1:0]         srl_res;
	logic [xlen-1:0]         sra_res;
	logic [wlen-1:0]         sllw_res;
	logic [wlen-1:0]         srlw_res;
	logic [wlen-1:0]         sraw_res;

	function automatic logic [xlen-1:0] sext_w(input logic [wlen-1:0] val);
		return {{(xlen-wlen){val[wlen-1]}}, val};
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		op_dec = '0;
		if (alu_op != alu_nop && int'(alu_op) <= alu_op_num)
			op_dec[alu_op] = 1'b1;
	end

	// compares and branches run through the subtractor.
	assign sub_path = op_dec[alu_sub]  | op_dec[alu_subw] | op_dec[alu_slt]
		| op_dec[alu_sltu] | op_dec[alu_beq]  | op_dec[alu_bne]
		| op_dec[alu_blt]  | op_dec[alu_bge]  | op_dec[alu_bltu]
		| op_dec[alu_bgeu];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// shared adder and shifter.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign op2_add = sub_path ? ~op2 : op2;	// two's complement with cin.

	adder64 adder_inst (
		.op1      (op1),
		.op2      (op2_add),
		.cin      (sub_path),
		.sum      (add_sum),
		.zero     (zero),
		.sign     (add_sign),
		.overflow (add_ovf),
		.carry    (lt_unsigned)
	);

	assign lt_signed = add_sign ^ add_ovf;

	assign shamt   = op2[shamt_bits-1:0];
	assign shamt_w = op2[shamt_w_bits-1:0];

	assign sll_res  = op1 << shamt;
	assign srl_res  = op1 >> shamt;
	assign sra_res  = $signed(op1) >>> shamt;
	assign sllw_res = op1[wlen-1:0] << shamt_w;
	assign srlw_res = op1[wlen-1:0] >> shamt_w;	// sign-extended below like the rest.
	assign sraw_res = $signed(op1[wlen-1:0]) >>> shamt_w;

	// one term per operation, branches fall out as 0.
	assign result = ({xlen{op_dec[alu_add] | op_dec[alu_sub]}} & add_sum)
		| ({xlen{op_dec[alu_addw] | op_dec[alu_subw]}} & sext_w(add_sum[wlen-1:0]))
		| ({xlen{op_dec[alu_slt]}}  & {{(xlen-1){1'b0}}, lt_signed})
		| ({xlen{op_dec[alu_sltu]}} & {{(xlen-1){1'b0}}, lt_unsigned})
		| ({xlen{op_dec[alu_xor]}}  & (op1 ^ op2))
		| ({xlen{op_dec[alu_or]}}   & (op1 | op2))
		| ({xlen{op_dec[alu_and]}}  & (op1 & op2))
		| ({xlen{op_dec[alu_sll]}}  & sll_res)
		| ({xlen{op_dec[alu_srl]}}  & srl_res)
		| ({xlen{op_dec[alu_sra]}}  & sra_res)
		| ({xlen{op_dec[alu_sllw]}} & sext_w(sllw_res))
		| ({xlen{op_dec[alu_srlw]}} & sext_w(srlw_res))
		| ({xlen{op_dec[alu_sraw]}} & sext_w(sraw_res))
		| ({xlen{op_dec[alu_lui]}}  & op2);

	// an undefined code would silently give 0, so it must never reach the alu.
	assert property (@(posedge clk) disable iff (reset)
		$onehot0(op_dec) && (op_dec != '0 || alu_op == alu_nop))
		else $error("alu_core: undefined alu_op %0d", alu_op);

endmodule

// File: src/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import isa_pkg::*, pipe_pkg::*; (
	input  alu_op_t         alu_op,
	input  logic            zero,
	input  logic            lt_signed,
	input  logic            lt_unsigned,
	input  pc_base_t        pc_base,
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] new_rs1,
	input  logic [xlen-1:0] imm,
	output logic            taken,
	output logic [xlen-1:0] target
);

	logic [xlen-1:0] base;
	logic [xlen-1:0] target_sum;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// branch condition.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// flags come from op1 - op2 in the alu.
	always_comb begin
		case (alu_op)
			alu_beq:  taken = zero;
			alu_bne:  taken = ~zero;
			alu_blt:  taken = lt_signed;
			alu_bge:  taken = ~lt_signed;
			alu_bltu: taken = lt_unsigned;
			alu_bgeu: taken = ~lt_unsigned;
			default:  taken = 1'b0;	// not a branch.
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// target address.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign base = (pc_base == base_rs1) ? new_rs1 : pc;

	adder64 target_adder_inst (
		.op1      (base),
		.op2      (imm),
		.cin      (1'b0),
		.sum      (target_sum),
		.zero     (),
		.sign     (),
		.overflow (),
		.carry    ()
	);

	// jalr drops the low bit of the sum.
	assign target = {target_sum[xlen-1:1],
		(pc_base == base_rs1) ? 1'b0 : target_sum[0]};

endmodule

// File: src/ex_mem_reg.sv
`timescale 1ns/1ps

module ex_mem_reg import isa_pkg::*; (
	input  logic            clk,
	input  logic            reset,
	input  logic            in_valid,
	input  logic            taken_in,
	input  logic [xlen-1:0] result_in,
	input  logic [xlen-1:0] store_in,
	input  logic [xlen-1:0] target_in,
	output logic            out_valid,
	output logic            taken,
	output logic [xlen-1:0] result,
	output logic [xlen-1:0] store_data,
	output logic [xlen-1:0] target
);

	// control bits.
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			taken     <= 1'b0;
		end else begin
			out_valid <= in_valid;
			taken     <= in_valid & taken_in;	// a bubble never branches.
		end
	end

	// payload holds through bubbles so the mem forward stays on the last result.
	always_ff @(posedge clk) begin
		if (reset) begin
			result     <= '0;
			store_data <= '0;
			target     <= '0;
		end else if (in_valid) begin
			result     <= result_in;
			store_data <= store_in;
			target     <= target_in;
		end
	end

	assert property (@(posedge clk) disable iff (reset) taken |-> out_valid)
		else $error("ex_mem_reg: taken set on an invalid slot");

endmodule

// File: src/exe_stage_top.sv
`timescale 1ns/1ps

module exe_stage_top import isa_pkg::*, pipe_pkg::*; (
	input  logic            clk,
	input  logic            reset,
	input  logic            in_valid,
	input  alu_op_t         alu_op,
	input  fwd_sel_t        rs1_src,
	input  fwd_sel_t        rs2_src,
	input  op1_sel_t        op1_src,
	input  op2_sel_t        op2_src,
	input  pc_base_t        pc_base,
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] imm,
	input  logic [xlen-1:0] rs1_data,
	input  logic [xlen-1:0] rs2_data,
	input  logic [xlen-1:0] wb_rd_data,
	output logic            out_valid,
	output logic [xlen-1:0] result,
	output logic [xlen-1:0] store_data,
	output logic            taken,
	output logic [xlen-1:0] target
);

	logic [xlen-1:0] new_rs1;
	logic [xlen-1:0] new_rs2;	// also the store data.
	logic [xlen-1:0] op1;
	logic [xlen-1:0] op2;
	logic [xlen-1:0] alu_result;
	logic            alu_zero;
	logic            alu_lt_signed;
	logic            alu_lt_unsigned;
	logic            br_taken;
	logic [xlen-1:0] br_target;

	// registered result goes back in as the mem-stage forward.
	operand_select operand_select_inst (
		.rs1_src    (rs1_src),
		.rs2_src    (rs2_src),
		.op1_src    (op1_src),
		.op2_src    (op2_src),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.mem_result (result),
		.wb_rd_data (wb_rd_data),
		.pc         (pc),
		.imm        (imm),
		.new_rs1    (new_rs1),
		.new_rs2    (new_rs2),
		.op1        (op1),
		.op2        (op2)
	);

	alu_core alu_core_inst (
		.clk         (clk),
		.reset       (reset),
		.alu_op      (alu_op),
		.op1         (op1),
		.op2         (op2),
		.result      (alu_result),
		.zero        (alu_zero),
		.lt_signed   (alu_lt_signed),
		.lt_unsigned (alu_lt_unsigned)
	);

	branch_unit branch_unit_inst (
		.alu_op      (alu_op),
		.zero        (alu_zero),
		.lt_signed   (alu_lt_signed),
		.lt_unsigned (alu_lt_unsigned),
		.pc_base     (pc_base),
		.pc          (pc),
		.new_rs1     (new_rs1),
		.imm         (imm),
		.taken       (br_taken),
		.target      (br_target)
	);

	ex_mem_reg ex_mem_reg_inst (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.taken_in   (br_taken),
		.result_in  (alu_result),
		.store_in   (new_rs2),
		.target_in  (br_target),
		.out_valid  (out_valid),
		.taken      (taken),
		.result     (result),
		.store_data (store_data),
		.target     (target)
	);

endmodule

// File: verif/exe_stage_tb.sv
`timescale 1ns/1ps

module exe_stage_tb import isa_pkg::*, pipe_pkg::*; ();

	localparam int num_vectors = 40;
	localparam int num_fields  = 17;	// 12 input columns, 5 expected columns.
	localparam int exp_offset  = 12;
	localparam int cycle_limit = num_vectors + 20;

	logic            clk;
	logic            reset;
	logic            in_valid;
	alu_op_t         alu_op;
	fwd_sel_t        rs1_src;
	fwd_sel_t        rs2_src;
	op1_sel_t        op1_src;
	op2_sel_t        op2_src;
	pc_base_t        pc_base;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	logic [xlen-1:0] wb_rd_data;
	logic            out_valid;
	logic [xlen-1:0] result;
	logic [xlen-1:0] store_data;
	logic            taken;
	logic [xlen-1:0] target;

	logic [63:0] vec_mem [0:num_vectors*num_fields-1];
	int          error_count = 0;
	int          check_count = 0;
	int          cycle_count = 0;

	exe_stage_top exe_stage_top_inst (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.alu_op     (alu_op),
		.rs1_src    (rs1_src),
		.rs2_src    (rs2_src),
		.op1_src    (op1_src),
		.op2_src    (op2_src),
		.pc_base    (pc_base),
		.pc         (pc),
		.imm        (imm),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.wb_rd_data (wb_rd_data),
		.out_valid  (out_valid),
		.result     (result),
		.store_data (store_data),
		.taken      (taken),
		.target     (target)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period.
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic compare_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic apply_vector(input int idx);
		int base;
		base       = idx * num_fields;
		in_valid   = vec_mem[base][0];
		alu_op     = alu_op_t'(vec_mem[base + 1][4:0]);
		rs1_src    = fwd_sel_t'(vec_mem[base + 2][1:0]);
		rs2_src    = fwd_sel_t'(vec_mem[base + 3][1:0]);
		op1_src    = op1_sel_t'(vec_mem[base + 4][0]);
		op2_src    = op2_sel_t'(vec_mem[base + 5][1:0]);
		pc_base    = pc_base_t'(vec_mem[base + 6][0]);
		pc         = vec_mem[base + 7];
		imm        = vec_mem[base + 8];
		rs1_data   = vec_mem[base + 9];
		rs2_data   = vec_mem[base + 10];
		wb_rd_data = vec_mem[base + 11];
	endtask

	task automatic check_vector(input int idx);
		int base;
		base = idx * num_fields + exp_offset;
		compare_value("out_valid", vec_mem[base], {63'b0, out_valid});
		compare_value("result", vec_mem[base + 1], result);
		compare_value("store_data", vec_mem[base + 2], store_data);
		compare_value("taken", vec_mem[base + 3], {63'b0, taken});
		compare_value("target", vec_mem[base + 4], target);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus and checks.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		reset      = 1'b1;
		in_valid   = 1'b0;
		alu_op     = alu_nop;
		rs1_src    = fwd_reg;
		rs2_src    = fwd_reg;
		op1_src    = op1_rs1;
		op2_src    = op2_rs2;
		pc_base    = base_pc;
		pc         = '0;
		imm        = '0;
		rs1_data   = '0;
		rs2_data   = '0;
		wb_rd_data = '0;
		$readmemh("verif/exe_testdata.txt", vec_mem);
		if ($isunknown(vec_mem[num_vectors*num_fields-1])) begin
			error_count++;
			$display("the vector file is missing or holds fewer vectors than expected");
		end

		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		// the register must come out of reset empty.
		compare_value("out_valid", '0, {63'b0, out_valid});
		compare_value("taken", '0, {63'b0, taken});
		compare_value("result", '0, result);
		compare_value("store_data", '0, store_data);
		compare_value("target", '0, target);

		for (int i = 0; i <= num_vectors; i++) begin
			if (i > 0)
				check_vector(i - 1);	// one cycle of latency.
			if (i < num_vectors)
				apply_vector(i);
			else
				in_valid = 1'b0;
			@(posedge clk);
			#1;
		end

		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("checks %0d, errors %0d", check_count, error_count);
			$display("Test failures found");
			$finish;
		end
	end

endmodule

// File: verif/exe_testdata.txt
// valid alu_op rs1_src rs2_src op1_src op2_src pc_base pc imm rs1_data rs2_data wb_rd_data
// then expected: out_valid result store_data taken target
1 01 0 0 0 0 0 1000 0 5 7 0 1 c 7 0 1000
1 01 0 0 0 0 0 1000 0 7fffffffffffffff 1 0 1 8000000000000000 1 0 1000
1 02 0 0 0 0 0 1000 0 8000000000000000 7fffffffffffffff 0 1 1 7fffffffffffffff 0 1000
1 03 0 0 0 0 0 1000 0 8000000000000000 7fffffffffffffff 0 1 0 7fffffffffffffff 0 1000
1 03 0 0 0 0 0 1000 0 1 ffffffffffffffff 0 1 1 ffffffffffffffff 0 1000
1 04 0 0 0 0 0 1000 0 ff00ff00ff00ff00 0ff00ff00ff00ff0 0 1 f0f0f0f0f0f0f0f0 0ff00ff00ff00ff0 0 1000
1 05 0 0 0 0 0 1000 0 ff00ff00ff00ff00 0ff00ff00ff00ff0 0 1 fff0fff0fff0fff0 0ff00ff00ff00ff0 0 1000
1 06 0 0 0 0 0 1000 0 ff00ff00ff00ff00 0ff00ff00ff00ff0 0 1 0f000f000f000f00 0ff00ff00ff00ff0 0 1000
1 07 0 0 0 1 0 1000 0 8000000000000001 0 0 1 8000000000000001 0 0 1000
1 07 0 0 0 1 0 1000 3f 3 0 0 1 8000000000000000 0 0 103f
1 08 0 0 0 1 0 1000 20 8000000000000000 0 0 1 80000000 0 0 1020
1 09 0 0 0 1 0 1000 3f 8000000000000000 0 0 1 ffffffffffffffff 0 0 103f
1 09 0 0 0 0 0 1000 0 8000000000000000 1f 0 1 ffffffff00000000 1f 0 1000
1 0a 0 0 0 0 0 1000 0 0 1 0 1 ffffffffffffffff 1 0 1000
1 0b 0 0 0 1 0 1000 ffffffff80000000 0 0 0 1 ffffffff80000000 0 0 ffffffff80001000
1 12 0 0 0 0 0 1000 0 7fffffff 1 0 1 ffffffff80000000 1 0 1000
1 13 0 0 0 0 0 1000 0 100000000 1 0 1 ffffffffffffffff 1 0 1000
1 14 0 0 0 1 0 1000 1f 1 0 0 1 ffffffff80000000 0 0 101f
1 15 0 0 0 1 0 1000 1f ffffffff80000000 0 0 1 1 0 0 101f
1 16 0 0 0 1 0 1000 1f 80000000 0 0 1 ffffffffffffffff 0 0 101f
1 15 0 0 0 1 0 1000 20 f0000000 0 0 1 fffffffff0000000 0 0 1020
1 01 2 0 0 0 0 1000 0 1111111111111111 23 100 1 123 23 0 1000
1 01 1 2 0 0 0 1000 0 0 ffff 1000 1 1123 1000 0 1000
1 0a 0 1 0 0 0 1000 0 2000 ffff 0 1 edd 1123 0 1000
0 0c 0 0 0 0 0 1000 0 5 5 0 0 edd 1123 0 1000
1 01 1 0 0 1 0 1000 3 0 0 0 1 ee0 0 0 1003
1 0c 0 0 0 0 0 2000 10 1234 1234 0 1 0 1234 1 2010
1 0c 0 0 0 0 0 2000 10 1234 1235 0 1 0 1235 0 2010
1 0d 0 0 0 0 0 2000 fffffffffffffff0 2 1 0 1 0 1 1 1ff0
1 0d 0 0 0 0 0 2000 10 7 7 0 1 0 7 0 2010
1 0e 0 0 0 0 0 2000 10 ffffffffffffffff 1 0 1 0 1 1 2010
1 0e 0 0 0 0 0 2000 10 1 ffffffffffffffff 0 1 0 ffffffffffffffff 0 2010
1 0f 0 0 0 0 0 2000 10 8000000000000000 8000000000000000 0 1 0 8000000000000000 1 2010
1 0f 0 0 0 0 0 2000 10 8000000000000000 7fffffffffffffff 0 1 0 7fffffffffffffff 0 2010
1 10 0 0 0 0 0 2000 10 1 ffffffffffffffff 0 1 0 ffffffffffffffff 1 2010
1 10 0 0 0 0 0 2000 10 5 5 0 1 0 5 0 2010
1 11 0 0 0 0 0 2000 10 ffffffffffffffff 1 0 1 0 1 1 2010
1 11 0 0 0 0 0 2000 10 0 8000000000000000 0 1 0 8000000000000000 0 2010
1 01 0 0 1 2 0 3000 100 0 0 0 1 3004 0 0 3100
1 01 1 0 1 2 1 3004 21 0 0 0 1 3008 0 0 3024

// File: src.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/adder64.sv
src/operand_select.sv
src/alu_core.sv
src/branch_unit.sv
src/ex_mem_reg.sv
src/exe_stage_top.sv
verif/exe_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the execute-stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module exe_stage_tb -o exe_stage_sim

./obj_dir/exe_stage_sim | tee sim.log

if grep -qx 'All tests passed!' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
